// File: design/icache_consts.svh
`ifndef ICACHE_CONSTS_SVH
`define ICACHE_CONSTS_SVH

// fetch and memory address width
`define ICACHE_ADDR_W       32
// instruction and bus word width
`define ICACHE_WORD_W       32

// address split: tag | index | offset
`define ICACHE_OFFSET_W     6
`define ICACHE_INDEX_W      7
`define ICACHE_TAG_W        19

// 128 lines of 64 bytes, 8 KB total
`define ICACHE_LINES        128
`define ICACHE_LINE_WORDS   16
// word within a line, offset without the byte bits
`define ICACHE_WSEL_W       4

// top address nibble of the uncached region
`define ICACHE_UNCACHED_TOP 4'hA

`endif

// File: design/icache_pkg.sv
`include "icache_consts.svh"

package icache_pkg;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    READ,
    COMPARE,
    REFILL,
    UNCACHED,
    RESPOND
  } icache_state_e;

  // address fields
  typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
  typedef logic [`ICACHE_INDEX_W-1:0] index_t;
  typedef logic [`ICACHE_WSEL_W-1:0]  wsel_t;

endpackage

// File: design/refill_counter.sv
`include "icache_consts.svh"

module refill_counter
  import icache_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  clr_i,
  input  logic  inc_i,
  output wsel_t cnt_o,
  output logic  last_o
);

  wsel_t cnt_q;

  // clear wins over advance
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (inc_i) begin
      // wraps to zero after the last word
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign cnt_o = cnt_q;

  // terminal word of the line
  assign last_o = (cnt_q == wsel_t'(`ICACHE_LINE_WORDS - 1));

endmodule

// File: design/icache_tag_array.sv
`include "icache_consts.svh"

module icache_tag_array
  import icache_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  index_t idx_i,
  input  tag_t   tag_i,
  input  logic   we_i,
  output logic   hit_o
);

  // tag storage, no reset needed, guarded by valid
  tag_t tag_mem [`ICACHE_LINES];
  // one valid bit per line
  logic [`ICACHE_LINES-1:0] valid_q;

  // registered read of the indexed entry
  tag_t rd_tag_q;
  logic rd_valid_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q    <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= valid_q[idx_i];
      // refill done, line becomes valid
      if (we_i) begin
        valid_q[idx_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_tag_q <= tag_mem[idx_i];
    if (we_i) begin
      tag_mem[idx_i] <= tag_i;
    end
  end

  // request tag held stable by the controller
  assign hit_o = rd_valid_q && (rd_tag_q == tag_i);

endmodule

// File: design/icache_data_array.sv
`include "icache_consts.svh"

module icache_data_array
  import icache_pkg::*;
(
  input  logic                      clk,
  input  index_t                    idx_i,
  input  wsel_t                     wsel_i,
  input  logic                      we_i,
  input  logic [`ICACHE_WORD_W-1:0] wdata_i,
  output logic [`ICACHE_WORD_W-1:0] rdata_o
);

  localparam int unsigned DEPTH = `ICACHE_LINES * `ICACHE_LINE_WORDS;
  localparam int unsigned AW    = `ICACHE_INDEX_W + `ICACHE_WSEL_W;

  // flat word storage, line index in the upper bits
  logic [`ICACHE_WORD_W-1:0] mem [DEPTH];

  logic [AW-1:0]             word_addr;
  logic [`ICACHE_WORD_W-1:0] rdata_q;

  assign word_addr = {idx_i, wsel_i};

  // one word per refill ack
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[word_addr] <= wdata_i;
    end
  end

  // registered read, old data on a same-cycle write
  always_ff @(posedge clk) begin
    rdata_q <= mem[word_addr];
  end

  assign rdata_o = rdata_q;

endmodule

// File: design/icache_ctrl.sv
`include "icache_consts.svh"

module icache_ctrl
  import icache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  // fetch side
  input  logic                      fetch_valid_i,
  input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
  output logic [`ICACHE_WORD_W-1:0] fetch_data_o,
  output logic                      fetch_valid_o,
  // wishbone classic read master
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic [`ICACHE_ADDR_W-1:0] wb_adr_o,
  input  logic [`ICACHE_WORD_W-1:0] wb_dat_i,
  input  logic                      wb_ack_i,
  // arrays
  output index_t                    idx_o,
  output tag_t                      tag_o,
  output wsel_t                     wsel_o,
  output logic                      tag_we_o,
  output logic                      data_we_o,
  output logic [`ICACHE_WORD_W-1:0] wdata_o,
  input  logic                      hit_i,
  input  logic [`ICACHE_WORD_W-1:0] rdata_i,
  // refill counter
  output logic                      cnt_clr_o,
  output logic                      cnt_inc_o,
  input  wsel_t                     cnt_i,
  input  logic                      cnt_last_i
);

  icache_state_e state_q;

  // captured request
  tag_t   req_tag_q;
  index_t req_idx_q;
  wsel_t  req_wsel_q;
  logic   uncached_q;

  // word held from an uncached read
  logic [`ICACHE_WORD_W-1:0] unc_data_q;

  // cyc and stb together
  logic wb_req_q;
  logic wb_done;
  logic req_uncached;
  logic [`ICACHE_ADDR_W-1:0] line_base;

  assign wb_done      = wb_req_q && wb_ack_i;
  assign req_uncached = (fetch_addr_i[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_UNCACHED_TOP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= IDLE;
      wb_req_q      <= 1'b0;
      fetch_valid_o <= 1'b0;
    end else begin
      // single-cycle pulse
      fetch_valid_o <= 1'b0;
      case (state_q)
        IDLE: begin
          // skip the pulse cycle, address may still be the old one
          if (fetch_valid_i && !fetch_valid_o) begin
            if (req_uncached) begin
              state_q  <= UNCACHED;
              wb_req_q <= 1'b1;
            end else begin
              state_q <= READ;
            end
          end
        end
        // arrays read at the captured index
        READ: begin
          state_q <= COMPARE;
        end
        COMPARE: begin
          if (hit_i) begin
            state_q <= RESPOND;
          end else begin
            state_q  <= REFILL;
            wb_req_q <= 1'b1;
          end
        end
        REFILL: begin
          if (wb_done) begin
            // drop cyc for a cycle between words
            wb_req_q <= 1'b0;
            if (cnt_last_i) begin
              // re-lookup, completes as a hit
              state_q <= READ;
            end
          end else begin
            wb_req_q <= 1'b1;
          end
        end
        UNCACHED: begin
          if (wb_done) begin
            wb_req_q <= 1'b0;
            state_q  <= RESPOND;
          end
        end
        RESPOND: begin
          fetch_valid_o <= 1'b1;
          state_q       <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (state_q == IDLE && fetch_valid_i && !fetch_valid_o) begin
      {req_tag_q, req_idx_q, req_wsel_q} <= fetch_addr_i[`ICACHE_ADDR_W-1:2];
      uncached_q <= req_uncached;
    end
    if (state_q == UNCACHED && wb_done) begin
      unc_data_q <= wb_dat_i;
    end
    if (state_q == RESPOND) begin
      fetch_data_o <= uncached_q ? unc_data_q : rdata_i;
    end
  end

  assign wb_cyc_o = wb_req_q;
  assign wb_stb_o = wb_req_q;

  // refill walks the line, uncached uses the word address
  assign line_base = {req_tag_q, req_idx_q, {`ICACHE_OFFSET_W{1'b0}}};
  assign wb_adr_o  = uncached_q ? {req_tag_q, req_idx_q, req_wsel_q, 2'b00}
                                : line_base + `ICACHE_ADDR_W'({cnt_i, 2'b00});

  // array side
  assign idx_o     = req_idx_q;
  assign tag_o     = req_tag_q;
  assign wsel_o    = (state_q == REFILL) ? cnt_i : req_wsel_q;
  assign wdata_o   = wb_dat_i;
  assign data_we_o = (state_q == REFILL) && wb_done;
  // tag written with the last word
  assign tag_we_o  = data_we_o && cnt_last_i;

  // counter restarts on every miss
  assign cnt_clr_o = (state_q == COMPARE) && !hit_i;
  assign cnt_inc_o = data_we_o;

endmodule

// File: design/icache_top.sv
`include "icache_consts.svh"

module icache_top
  import icache_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_valid_i,
  input  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i,
  output logic [`ICACHE_WORD_W-1:0] fetch_data_o,
  output logic                      fetch_valid_o,
  output logic                      wb_cyc_o,
  output logic                      wb_stb_o,
  output logic [`ICACHE_ADDR_W-1:0] wb_adr_o,
  input  logic [`ICACHE_WORD_W-1:0] wb_dat_i,
  input  logic                      wb_ack_i
);

  // controller to arrays
  index_t                    idx;
  tag_t                      tag;
  wsel_t                     wsel;
  logic                      tag_we;
  logic                      data_we;
  logic [`ICACHE_WORD_W-1:0] wdata;
  // arrays back to controller
  logic                      hit;
  logic [`ICACHE_WORD_W-1:0] rdata;
  // refill counter
  logic                      cnt_clr;
  logic                      cnt_inc;
  wsel_t                     cnt;
  logic                      cnt_last;

  icache_ctrl icache_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_data_o  (fetch_data_o),
    .fetch_valid_o (fetch_valid_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .idx_o         (idx),
    .tag_o         (tag),
    .wsel_o        (wsel),
    .tag_we_o      (tag_we),
    .data_we_o     (data_we),
    .wdata_o       (wdata),
    .hit_i         (hit),
    .rdata_i       (rdata),
    .cnt_clr_o     (cnt_clr),
    .cnt_inc_o     (cnt_inc),
    .cnt_i         (cnt),
    .cnt_last_i    (cnt_last)
  );

  refill_counter refill_counter_inst (
    .clk    (clk),
    .rst    (rst),
    .clr_i  (cnt_clr),
    .inc_i  (cnt_inc),
    .cnt_o  (cnt),
    .last_o (cnt_last)
  );

  icache_tag_array icache_tag_array_inst (
    .clk   (clk),
    .rst   (rst),
    .idx_i (idx),
    .tag_i (tag),
    .we_i  (tag_we),
    .hit_o (hit)
  );

  icache_data_array icache_data_array_inst (
    .clk     (clk),
    .idx_i   (idx),
    .wsel_i  (wsel),
    .we_i    (data_we),
    .wdata_i (wdata),
    .rdata_o (rdata)
  );

endmodule

// File: test/icache_chk.sv
`include "icache_consts.svh"

module icache_chk
  import icache_pkg::*;
(
  input logic                      clk,
  input logic                      rst,
  input icache_state_e             state_i,
  input logic                      wb_cyc_i,
  input logic                      wb_stb_i,
  input logic [`ICACHE_ADDR_W-1:0] wb_adr_i,
  input logic                      wb_ack_i,
  input logic                      resp_valid_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // strobe only inside a bus cycle, and only in the states that run one
  stb_in_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_stb_i |-> (wb_cyc_i && (state_i == REFILL || state_i == UNCACHED)))
    else $error("wishbone stb high without cyc or outside a bus state");

  // address held until the slave acks
  adr_stable: assert property (@(posedge clk) disable iff (rst)
    (wb_stb_i && !wb_ack_i) |=> $stable(wb_adr_i))
    else $error("wishbone address changed before ack");

  // response is a one-cycle pulse
  resp_pulse: assert property (@(posedge clk) disable iff (rst) resp_valid_i |=> !resp_valid_i)
    else $error("fetch_valid_o high for two cycles");

endmodule

bind icache_ctrl icache_chk icache_chk_inst (
  .clk          (clk),
  .rst          (rst),
  .state_i      (state_q),
  .wb_cyc_i     (wb_cyc_o),
  .wb_stb_i     (wb_stb_o),
  .wb_adr_i     (wb_adr_o),
  .wb_ack_i     (wb_ack_i),
  .resp_valid_i (fetch_valid_o)
);

// File: test/icache_tb.sv
`include "icache_consts.svh"

module icache_tb;
  timeunit 1ns;
  timeprecision 100ps;

  // upper bound for any wait, in clock cycles
  localparam int TIMEOUT_CYCLES = 400;

  logic                      clk;
  logic                      rst;
  logic                      fetch_valid_i;
  logic [`ICACHE_ADDR_W-1:0] fetch_addr_i;
  logic [`ICACHE_WORD_W-1:0] fetch_data_o;
  logic                      fetch_valid_o;
  logic                      wb_cyc_o;
  logic                      wb_stb_o;
  logic [`ICACHE_ADDR_W-1:0] wb_adr_o;
  logic [`ICACHE_WORD_W-1:0] wb_dat_i;
  logic                      wb_ack_i;

  int value_errs;
  int other_errs;
  int timeouts;

  // address of every bus cycle the memory model saw
  logic [`ICACHE_ADDR_W-1:0] adr_log [$];

  icache_top icache_top_inst (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_data_o  (fetch_data_o),
    .fetch_valid_o (fetch_valid_o),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // memory content, aligned address xor a fixed pattern
  function automatic logic [`ICACHE_WORD_W-1:0] mem_word(input logic [`ICACHE_ADDR_W-1:0] addr);
    return {addr[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'h5A5A_0000;
  endfunction

  // wishbone slave, 0 to 3 wait cycles per strobe
  initial begin
    int unsigned wait_left;
    bit          busy;
    wb_ack_i  = 1'b0;
    wb_dat_i  = '0;
    wait_left = 0;
    busy      = 1'b0;
    void'($urandom(32'he790c561));
    forever begin
      @(posedge clk);
      #1;
      if (wb_ack_i) begin
        // ack lasts one cycle
        wb_ack_i = 1'b0;
      end else if (wb_cyc_o && wb_stb_o) begin
        // new strobe, pick its delay once
        if (!busy) begin
          busy      = 1'b1;
          wait_left = $urandom % 4;
          adr_log.push_back(wb_adr_o);
        end
        if (wait_left == 0) begin
          wb_ack_i = 1'b1;
          wb_dat_i = mem_word(wb_adr_o);
          busy     = 1'b0;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  task automatic end_run();
    $display("errors: value %0d, other %0d, timeouts %0d", value_errs, other_errs, timeouts);
    if (value_errs == 0 && other_errs == 0 && timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  // one request, waits for the response pulse
  task automatic do_fetch(input logic [`ICACHE_ADDR_W-1:0] addr,
                          output logic [`ICACHE_WORD_W-1:0] data, output int cycles);
    int n;
    // nothing more goes on the bus once a wait has run out
    if (timeouts != 0) begin
      return;
    end
    n             = 0;
    fetch_addr_i  = addr;
    fetch_valid_i = 1'b1;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!fetch_valid_o && n < TIMEOUT_CYCLES);
    if (!fetch_valid_o) begin
      $display("no fetch response for address %h in %0d cycles", addr, TIMEOUT_CYCLES);
      timeouts++;
    end else begin
      data          = fetch_data_o;
      cycles        = n;
      fetch_valid_i = 1'b0;
      // idle cycle, keeps the next request clear of the pulse
      @(posedge clk);
      #1;
    end
  endtask

  task automatic reset_quiet();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      if (wb_cyc_o !== 1'b0) begin
        $display("Fail wb_cyc_o: got %h expected 0 around reset", wb_cyc_o);
        value_errs++;
      end
      if (fetch_valid_o !== 1'b0) begin
        $display("Fail fetch_valid_o: got %h expected 0 around reset", fetch_valid_o);
        value_errs++;
      end
      // released after the second edge
      if (i == 1) begin
        rst = 1'b0;
      end
    end
  endtask

  // miss on addr, whole line read in order
  task automatic check_refill(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [`ICACHE_WORD_W-1:0] data;
    logic [`ICACHE_ADDR_W-1:0] base;
    int cycles;
    int first;
    first = adr_log.size();
    base  = {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
    do_fetch(addr, data, cycles);
    if (timeouts != 0) begin
      return;
    end
    if (data !== mem_word(addr)) begin
      $display("Fail fetch_data_o: got %h expected %h", data, mem_word(addr));
      value_errs++;
    end
    if (adr_log.size() - first != `ICACHE_LINE_WORDS) begin
      $display("refill for %h made %0d bus cycles, not 16", addr, adr_log.size() - first);
      other_errs++;
    end else begin
      for (int i = 0; i < `ICACHE_LINE_WORDS; i++) begin
        if (adr_log[first + i] !== base + 32'(4 * i)) begin
          $display("Fail wb_adr_o: got %h expected %h", adr_log[first + i], base + 32'(4 * i));
          value_errs++;
        end
      end
    end
  endtask

  // every other word of a line already present
  task automatic hit_other_words(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [`ICACHE_WORD_W-1:0] data;
    logic [`ICACHE_ADDR_W-1:0] word_addr;
    int cycles;
    int first;
    for (int w = 0; w < `ICACHE_LINE_WORDS; w += 2) begin
      word_addr = {addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}} + 32'(4 * w);
      first     = adr_log.size();
      do_fetch(word_addr, data, cycles);
      if (timeouts != 0) begin
        return;
      end
      if (data !== mem_word(word_addr)) begin
        $display("Fail fetch_data_o: got %h expected %h", data, mem_word(word_addr));
        value_errs++;
      end
      if (cycles != 4) begin
        $display("hit at %h answered after %0d cycles instead of 4", word_addr, cycles);
        other_errs++;
      end
      if (adr_log.size() != first) begin
        $display("hit at %h started a bus cycle", word_addr);
        other_errs++;
      end
    end
  endtask

  // same index, other tag, then back to the first line
  task automatic conflict_evict(input logic [`ICACHE_ADDR_W-1:0] addr);
    check_refill(addr ^ 32'h0010_0000);
    check_refill(addr);
  endtask

  task automatic uncached_twice(input logic [`ICACHE_ADDR_W-1:0] addr);
    logic [`ICACHE_WORD_W-1:0] data;
    int cycles;
    int first;
    // never cached, so both fetches go to the bus
    repeat (2) begin
      first = adr_log.size();
      do_fetch(addr, data, cycles);
      if (timeouts != 0) begin
        return;
      end
      if (data !== mem_word(addr)) begin
        $display("Fail fetch_data_o: got %h expected %h", data, mem_word(addr));
        value_errs++;
      end
      if (adr_log.size() - first != 1) begin
        $display("uncached fetch made %0d bus cycles, not 1", adr_log.size() - first);
        other_errs++;
      end else if (adr_log[first] !== {addr[`ICACHE_ADDR_W-1:2], 2'b00}) begin
        $display("Fail wb_adr_o: got %h expected %h", adr_log[first],
                 {addr[`ICACHE_ADDR_W-1:2], 2'b00});
        value_errs++;
      end
    end
  endtask

  initial begin
    value_errs    = 0;
    other_errs    = 0;
    timeouts      = 0;
    rst           = 1'b1;
    fetch_valid_i = 1'b0;
    fetch_addr_i  = '0;
    reset_quiet();
    // cold miss on index 0x49, word 2
    check_refill(32'h0000_1248);
    hit_other_words(32'h0000_1248);
    conflict_evict(32'h0000_1248);
    uncached_twice(32'hA000_0124);
    end_run();
  end

endmodule

// File: icache_top.f
+incdir+design
design/icache_pkg.sv
design/refill_counter.sv
design/icache_tag_array.sv
design/icache_data_array.sv
design/icache_ctrl.sv
design/icache_top.sv
test/icache_chk.sv
test/icache_tb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/1ps
TOP       := icache_tb
FILELIST  := icache_top.f
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	@out="$$(./$(OBJ_DIR)/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
